// ==== logic/isaPkg.sv ====
package isaPkg;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    typedef logic [5:0] opcodeT;                 // Bits 31:26 of the instruction
    typedef logic [5:0] functT;                  // Bits 5:0, R-type only

    ////////////////////////////////////////////////////////////
    // Opcode encodings
    ////////////////////////////////////////////////////////////

    localparam opcodeT opRType = 6'h00;          // Operation given by funct
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    // R-type function codes
    localparam functT fnAdd = 6'h20;
    localparam functT fnSub = 6'h22;
    localparam functT fnAnd = 6'h24;
    localparam functT fnOr  = 6'h25;
    localparam functT fnSlt = 6'h2a;

    ////////////////////////////////////////////////////////////
    // Decoded instruction kinds
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        kAdd,
        kSub,
        kAnd,
        kOr,
        kSlt,
        kAddi,
        kAddiu,
        kSlti,
        kBeq,
        kBne,
        kLw,
        kSw,
        kJump,
        kJal,
        kInvalid                                 // Anything outside the supported set
    } instrKindT;

endpackage

// ==== logic/controlPkg.sv ====
package controlPkg;

    ////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        sReset,                                  // Stack pointer preload
        sFetch1,                                 // Memory read of the instruction
        sFetch2,                                 // IR load and PC + 4
        sDecode,                                 // PC update and dispatch
        sAluR,
        sAluI,
        sWriteRd,
        sWriteRt,
        sMemCalc,                                // Base + offset
        sMemRead,
        sLoadWord,
        sStoreWord,
        sBranchCalc,                             // Branch target into ALUOut
        sBranchCmp,
        sBranchDone,
        sJump,
        sJal,
        sInvalidOp,
        sOverflow,
        sException                               // Jump to the vector
    } stateT;

    // ALU operation codes, as understood by the datapath ALU
    typedef logic [4:0] aluOpT;

    localparam aluOpT aluLoad     = 5'b00000;    // Pass A
    localparam aluOpT aluAddOvf   = 5'b00001;    // Add with overflow detect
    localparam aluOpT aluSub      = 5'b00010;
    localparam aluOpT aluAnd      = 5'b00011;
    localparam aluOpT aluCmp      = 5'b00111;    // Set on less than
    localparam aluOpT aluOr       = 5'b01000;
    localparam aluOpT aluAddNoOvf = 5'b01011;
    localparam aluOpT aluNe       = 5'b01110;
    localparam aluOpT aluEq       = 5'b01111;

    ////////////////////////////////////////////////////////////
    // Datapath selects
    ////////////////////////////////////////////////////////////

    typedef logic [1:0] aluSrcBT;
    localparam aluSrcBT bReg       = 2'd0;
    localparam aluSrcBT bFour      = 2'd1;
    localparam aluSrcBT bImm       = 2'd2;       // Sign-extended immediate
    localparam aluSrcBT bBranchOff = 2'd3;       // Immediate shifted left by 2

    typedef logic [1:0] regDestT;
    localparam regDestT destRt = 2'd0;
    localparam regDestT destRd = 2'd1;
    localparam regDestT destRa = 2'd2;           // $31
    localparam regDestT destSp = 2'd3;           // $29

    typedef logic [2:0] regSrcT;
    localparam regSrcT srcAluOut    = 3'd0;
    localparam regSrcT srcMemory    = 3'd1;
    localparam regSrcT srcStackInit = 3'd2;      // Initial stack pointer constant
    localparam regSrcT srcExcData   = 3'd3;
    localparam regSrcT srcPc        = 3'd4;

    typedef logic [2:0] pcSrcT;
    localparam pcSrcT pcJump      = 3'd0;
    localparam pcSrcT pcAluResult = 3'd1;        // Live ALU output
    localparam pcSrcT pcAluOut    = 3'd2;        // Registered ALU output
    localparam pcSrcT pcVector    = 3'd3;        // Exception vector from memory

    typedef logic [1:0] excCauseT;
    localparam excCauseT causeNone     = 2'd0;
    localparam excCauseT causeOverflow = 2'd1;
    localparam excCauseT causeInvalid  = 2'd2;

    // Phase counter and phase lengths in cycles
    typedef logic [1:0] waitT;
    localparam waitT resetCycles   = 2'd2;
    localparam waitT fetchCycles   = 2'd2;
    localparam waitT memReadCycles = 2'd2;
    localparam waitT loadCycles    = 2'd2;

endpackage

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder
    import isaPkg::*;
(
    input  opcodeT    opcode,
    input  functT     funct,
    output instrKindT instrKind
);

    ////////////////////////////////////////////////////////////
    // Opcode and funct lookup
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (opcode)
            opRType:
            begin
                case (funct)
                    fnAdd:   instrKind = kAdd;
                    fnSub:   instrKind = kSub;
                    fnAnd:   instrKind = kAnd;
                    fnOr:    instrKind = kOr;
                    fnSlt:   instrKind = kSlt;
                    default: instrKind = kInvalid;  // Shifts, mult, div and the rest
                endcase
            end
            opAddi:  instrKind = kAddi;
            opAddiu: instrKind = kAddiu;
            opSlti:  instrKind = kSlti;
            opBeq:   instrKind = kBeq;
            opBne:   instrKind = kBne;
            opLw:    instrKind = kLw;
            opSw:    instrKind = kSw;
            opJ:     instrKind = kJump;
            opJal:   instrKind = kJal;
            default: instrKind = kInvalid;
        endcase
    end

    // An unknown instruction register falls through to kInvalid and
    // would send the FSM into a false exception
    always_comb
    begin
        assert (!$isunknown({opcode, funct}))
        else
            $error("instrDecoder: unknown opcode %h or funct %h", opcode, funct);
    end

endmodule

// ==== logic/stateSequencer.sv ====
`timescale 1ns/1ns

module stateSequencer
    import isaPkg::*;
    import controlPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  instrKindT instrKind,
    input  logic      overflowFlag,
    output stateT     state,
    output waitT      waitCount
);

    stateT      nextState;
    logic [3:0] fetchGap;                        // Cycles spent away from sFetch1

    // Counter value loaded on entry, one less than the phase length
    function automatic waitT phaseLoad(input stateT target);
        waitT len;
        case (target)
            sReset:    len = resetCycles;
            sFetch1:   len = fetchCycles;
            sMemRead:  len = memReadCycles;
            sLoadWord: len = loadCycles;
            default:   len = 2'd1;               // Single-cycle states
        endcase
        return len - 2'd1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Successor state
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        nextState = state;
        case (state)
            sReset:      nextState = (waitCount == 2'd0) ? sFetch1 : sReset;
            sFetch1:     nextState = (waitCount == 2'd0) ? sFetch2 : sFetch1;
            sFetch2:     nextState = sDecode;
            sDecode:
            begin
                case (instrKind)
                    kAdd, kSub, kAnd, kOr, kSlt: nextState = sAluR;
                    kAddi, kAddiu, kSlti:        nextState = sAluI;
                    kBeq, kBne:                  nextState = sBranchCalc;
                    kLw, kSw:                    nextState = sMemCalc;
                    kJump:                       nextState = sJump;
                    kJal:                        nextState = sJal;
                    default:                     nextState = sInvalidOp;
                endcase
            end
            sAluR:       nextState = sWriteRd;
            sAluI:       nextState = sWriteRt;
            sMemCalc:    nextState = (instrKind == kSw) ? sStoreWord : sMemRead;
            sMemRead:    nextState = (waitCount == 2'd0) ? sLoadWord : sMemRead;
            sLoadWord:   nextState = (waitCount == 2'd0) ? sFetch1 : sLoadWord;
            sBranchCalc: nextState = sBranchCmp;
            sBranchCmp:  nextState = sBranchDone;
            sInvalidOp:  nextState = sException;
            sOverflow:   nextState = sException;
            sWriteRd, sWriteRt, sStoreWord, sBranchDone, sJump, sJal, sException:
                nextState = sFetch1;
            default:     nextState = sFetch1;
        endcase

        // Arithmetic overflow preempts the normal flow
        if (state != sReset && overflowFlag)
        begin
            nextState = sOverflow;
        end
    end

    ////////////////////////////////////////////////////////////
    // State register and phase counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= sReset;
            waitCount <= phaseLoad(sReset);
        end
        else
        begin
            state <= nextState;
            if (nextState != state)
                waitCount <= phaseLoad(nextState);  // Load on entry
            else
                waitCount <= waitCount - 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || state == sFetch1)
            fetchGap <= 4'd0;
        else if (fetchGap != 4'hf)
            fetchGap <= fetchGap + 4'd1;            // Saturates
    end

    // Longest path is lw plus one overflow detour, well inside this bound
    assert property (@(posedge clk) disable iff (reset)
        state != sFetch1 |-> fetchGap < 4'd12)
    else
        $error("stateSequencer: no return to sFetch1 within 12 cycles");

    assert property (@(posedge clk) disable iff (reset)
        state == sException |-> ($past(state) == sOverflow || $past(state) == sInvalidOp))
    else
        $error("stateSequencer: sException entered from state %0d", $past(state));

endmodule

// ==== logic/controlDecoder.sv ====
`timescale 1ns/1ns

module controlDecoder
    import isaPkg::*;
    import controlPkg::*;
(
    input  stateT     state,
    input  waitT      waitCount,
    input  instrKindT instrKind,
    output logic      pcWriteCond,
    output logic      pcWrite,
    output logic      iOrD,
    output logic      memWrite,
    output logic      irWrite,
    output logic      regWrite,
    output logic      aluSrcA,
    output excCauseT  excCause,
    output regDestT   regDest,
    output regSrcT    memToReg,
    output aluSrcBT   aluSrcB,
    output aluOpT     aluControl,
    output pcSrcT     pcSource
);

    // ALU code for the execute phase of each arithmetic or compare kind
    function automatic aluOpT aluOpFor(input instrKindT kind);
        case (kind)
            kAdd, kAddi: return aluAddOvf;
            kAddiu:      return aluAddNoOvf;
            kSub:        return aluSub;
            kAnd:        return aluAnd;
            kOr:         return aluOr;
            kSlt, kSlti: return aluCmp;
            kBne:        return aluNe;
            kBeq:        return aluEq;
            default:     return aluLoad;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Per-state outputs
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        pcWriteCond = 1'b0;
        pcWrite     = 1'b0;
        iOrD        = 1'b0;                      // Address from PC
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aluSrcA     = 1'b0;                      // A input is the PC
        excCause    = causeNone;
        regDest     = destRt;
        memToReg    = srcAluOut;
        aluSrcB     = bReg;
        aluControl  = aluLoad;
        pcSource    = pcAluOut;

        case (state)
            sReset:
            begin
                regDest  = destSp;
                memToReg = srcStackInit;
                regWrite = 1'b1;
            end
            sFetch2:
            begin
                aluSrcB    = bFour;
                aluControl = aluAddNoOvf;        // PC + 4
                irWrite    = (waitCount == 2'd0);
            end
            sDecode:
            begin
                aluSrcB    = bFour;
                aluControl = aluAddNoOvf;
                pcSource   = pcAluResult;
                pcWrite    = 1'b1;
            end
            sAluR, sAluI, sBranchCmp:
            begin
                aluSrcA    = 1'b1;
                aluSrcB    = (state == sAluI) ? bImm : bReg;
                aluControl = aluOpFor(instrKind);
                pcWriteCond = (state == sBranchCmp);  // PC from ALUOut if taken
            end
            sWriteRd, sWriteRt:
            begin
                regDest  = (state == sWriteRd) ? destRd : destRt;
                regWrite = 1'b1;
            end
            sMemCalc, sMemRead, sStoreWord:
            begin
                aluSrcA    = 1'b1;
                aluSrcB    = bImm;
                aluControl = aluAddNoOvf;        // Hold base + offset
                iOrD       = (state != sMemCalc);
                memWrite   = (state == sStoreWord);
            end
            sLoadWord:
            begin
                iOrD     = 1'b1;
                memToReg = srcMemory;
                regWrite = 1'b1;
            end
            sBranchCalc:
            begin
                aluSrcB    = bBranchOff;
                aluControl = aluAddNoOvf;        // Target into ALUOut
            end
            sBranchDone:
            begin
                aluSrcA = 1'b1;                  // Inputs held while PC settles
            end
            sJump, sJal:
            begin
                pcSource = pcJump;
                pcWrite  = 1'b1;
                if (state == sJal)
                begin
                    regDest  = destRa;
                    memToReg = srcPc;            // Return address is PC + 4
                    regWrite = 1'b1;
                end
            end
            sInvalidOp, sOverflow:
            begin
                excCause = (state == sOverflow) ? causeOverflow : causeInvalid;
                memToReg = srcExcData;
                pcSource = pcVector;
            end
            sException:
            begin
                memToReg = srcExcData;
                pcSource = pcVector;
                pcWrite  = 1'b1;
            end
            default:
            begin
                iOrD = 1'b0;                     // sFetch1 reads at PC
            end
        endcase

        assert (!(pcWrite && pcWriteCond))
        else
            $error("controlDecoder: pcWrite and pcWriteCond both high in %s", state.name());
    end

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit
    import isaPkg::*;
    import controlPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  opcodeT   opcode,
    input  functT    funct,
    input  logic     overflowFlag,
    output logic     pcWriteCond,
    output logic     pcWrite,
    output logic     iOrD,
    output logic     memWrite,
    output logic     irWrite,
    output logic     regWrite,
    output logic     aluSrcA,
    output excCauseT excCause,
    output regDestT  regDest,
    output regSrcT   memToReg,
    output aluSrcBT  aluSrcB,
    output aluOpT    aluControl,
    output pcSrcT    pcSource
);

    instrKindT instrKind;
    stateT     state;
    waitT      waitCount;

    ////////////////////////////////////////////////////////////
    // Instruction decode, sequencing and output decode
    ////////////////////////////////////////////////////////////

    instrDecoder instrDecoder_inst (
        .opcode    (opcode),
        .funct     (funct),
        .instrKind (instrKind)
    );

    stateSequencer stateSequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .instrKind    (instrKind),
        .overflowFlag (overflowFlag),
        .state        (state),
        .waitCount    (waitCount)
    );

    controlDecoder controlDecoder_inst (
        .state       (state),
        .waitCount   (waitCount),
        .instrKind   (instrKind),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .iOrD        (iOrD),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aluSrcA     (aluSrcA),
        .excCause    (excCause),
        .regDest     (regDest),
        .memToReg    (memToReg),
        .aluSrcB     (aluSrcB),
        .aluControl  (aluControl),
        .pcSource    (pcSource)
    );

endmodule

// ==== verification/controlChecker.sv ====
`timescale 1ns/1ns

module controlChecker
    import isaPkg::*;
    import controlPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  opcodeT   opcode,
    input  functT    funct,
    input  logic     overflowFlag,
    input  logic     pcWriteCond,
    input  logic     pcWrite,
    input  logic     iOrD,
    input  logic     memWrite,
    input  logic     irWrite,
    input  logic     regWrite,
    input  logic     aluSrcA,
    input  excCauseT excCause,
    input  regDestT  regDest,
    input  regSrcT   memToReg,
    input  aluSrcBT  aluSrcB,
    input  aluOpT    aluControl,
    input  pcSrcT    pcSource,
    output int       errorCount
);

    initial errorCount = 0;

    // Expected execute-phase ALU code, aluLoad for anything that is not ALU-type
    function automatic aluOpT expectedAluOp(input opcodeT op, input functT fn);
        if (op == opRType)
        begin
            case (fn)
                fnAdd:   return aluAddOvf;
                fnSub:   return aluSub;
                fnAnd:   return aluAnd;
                fnOr:    return aluOr;
                fnSlt:   return aluCmp;
                default: return aluLoad;
            endcase
        end
        case (op)
            opAddi:  return aluAddOvf;
            opAddiu: return aluAddNoOvf;
            opSlti:  return aluCmp;
            default: return aluLoad;
        endcase
    endfunction

    function automatic logic isAluKind(input opcodeT op, input functT fn);
        return expectedAluOp(op, fn) != aluLoad;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reset and ALU-type instructions
    ////////////////////////////////////////////////////////////

    resetPreload: assert property (@(posedge clk)
        $fell(reset) |-> (regWrite && regDest == destSp && memToReg == srcStackInit)
        ##1 (regWrite && regDest == destSp && memToReg == srcStackInit)
        ##1 !regWrite ##1 !irWrite ##1 irWrite ##1 !irWrite)
    else
    begin
        errorCount++;
        $display("Stack pointer preload or first fetch after reset is out of sequence");
    end

    aluCode: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 isAluKind(opcode, funct) |=> aluControl == expectedAluOp(opcode, funct))
    else
    begin
        errorCount++;
        $display("Fail aluCode: expected %h, actual %h", expectedAluOp(opcode, funct),
                 aluControl);
    end

    // R-type takes B from the register file, I-type from the immediate
    aluOperands: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 isAluKind(opcode, funct) |=> aluSrcA
        && aluSrcB == ((opcode == opRType) ? bReg : bImm))
    else
    begin
        errorCount++;
        $display("Fail aluOperands: expected srcA 1 srcB %h, actual srcA %b srcB %h",
                 (opcode == opRType) ? bReg : bImm, aluSrcA, aluSrcB);
    end

    aluWriteBack: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 isAluKind(opcode, funct) ##1 !overflowFlag |=>
        regWrite && memToReg == srcAluOut
        && regDest == ((opcode == opRType) ? destRd : destRt))
    else
    begin
        errorCount++;
        $display("Fail aluWriteBack: expected dest %h, actual regWrite %b dest %h src %h",
                 (opcode == opRType) ? destRd : destRt, regWrite, regDest, memToReg);
    end

    ////////////////////////////////////////////////////////////
    // Memory, branch and jump
    ////////////////////////////////////////////////////////////

    loadWord: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 opcode == opLw |=> !iOrD ##1 iOrD ##1 iOrD
        ##1 (regWrite && memToReg == srcMemory) ##1 (regWrite && memToReg == srcMemory)
        ##1 !regWrite)
    else
    begin
        errorCount++;
        $display("lw did not drive iOrD and the two-cycle memory write-back in order");
    end

    storeWord: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 opcode == opSw |=> (!memWrite && !regWrite)
        ##1 (memWrite && iOrD && !regWrite) ##1 (!memWrite && !regWrite))
    else
    begin
        errorCount++;
        $display("sw did not pulse memWrite for one cycle or wrote the register file");
    end

    branchCompare: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 (opcode == opBeq || opcode == opBne) |=> !pcWriteCond
        ##1 (pcWriteCond && aluControl == ((opcode == opBeq) ? aluEq : aluNe)) ##1 !pcWriteCond)
    else
    begin
        errorCount++;
        $display("Fail branchCompare: expected %h, actual %h",
                 (opcode == opBeq) ? aluEq : aluNe, aluControl);
    end

    jumpTarget: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 (opcode == opJ || opcode == opJal) |=> pcWrite && pcSource == pcJump
        && regWrite == (opcode == opJal)
        && (opcode == opJ || (regDest == destRa && memToReg == srcPc)))
    else
    begin
        errorCount++;
        $display("Fail jumpTarget: expected regWrite %b, actual %b (pcSource %h dest %h)",
                 opcode == opJal, regWrite, pcSource, regDest);
    end

    ////////////////////////////////////////////////////////////
    // Exceptions
    ////////////////////////////////////////////////////////////

    invalidCause: assert property (@(posedge clk) disable iff (reset)
        irWrite ##1 (opcode == 6'h3f) |=> excCause == causeInvalid)
    else
    begin
        errorCount++;
        $display("Fail invalidCause: expected %h, actual %h", causeInvalid, excCause);
    end

    overflowCause: assert property (@(posedge clk) disable iff (reset)
        overflowFlag |=> excCause == causeOverflow)
    else
    begin
        errorCount++;
        $display("Fail overflowCause: expected %h, actual %h", causeOverflow, excCause);
    end

    exceptionJump: assert property (@(posedge clk) disable iff (reset)
        excCause != causeNone |=> (excCause == causeNone && pcWrite && pcSource == pcVector)
        ##3 irWrite)
    else
    begin
        errorCount++;
        $display("Exception entry did not jump to the vector and refetch");
    end

endmodule

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ns

module controlUnitTb
    import isaPkg::*;
    import controlPkg::*;
();

    logic     clk;
    logic     reset;
    opcodeT   opcode;
    functT    funct;
    logic     overflowFlag;
    logic     pcWriteCond, pcWrite, iOrD, memWrite, irWrite, regWrite, aluSrcA;
    excCauseT excCause;
    regDestT  regDest;
    regSrcT   memToReg;
    aluSrcBT  aluSrcB;
    aluOpT    aluControl;
    pcSrcT    pcSource;
    int       errorCount;
    int       timeoutCount;
    logic     pulseOverflow;

    controlUnit controlUnit_inst (.*);

    controlChecker controlChecker_inst (.*);

    // Script entry as {overflow pulse, opcode, funct}
    function automatic logic [12:0] scriptEntry(input int idx);
        case (idx)
            0:       return {1'b0, opRType, fnAdd};
            1:       return {1'b0, opRType, fnSub};
            2:       return {1'b0, opRType, fnAnd};
            3:       return {1'b0, opRType, fnOr};
            4:       return {1'b0, opRType, fnSlt};
            5:       return {1'b0, opAddi, 6'h00};
            6:       return {1'b0, opAddiu, 6'h00};
            7:       return {1'b0, opSlti, 6'h00};
            8:       return {1'b0, opBeq, 6'h00};
            9:       return {1'b0, opBne, 6'h00};
            10:      return {1'b0, opLw, 6'h00};
            11:      return {1'b0, opSw, 6'h00};
            12:      return {1'b0, opJ, 6'h00};
            13:      return {1'b0, opJal, 6'h00};
            14:      return {1'b0, 6'h3f, 6'h00};   // Unused opcode
            default: return {1'b1, opAddi, 6'h00};
        endcase
    endfunction

    // Returns in the cycle where irWrite is high, 5 ns after its edge
    task automatic waitForIrWrite();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #5;
        while (!irWrite && cycles < 40)
        begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (!irWrite)
        begin
            timeoutCount++;
            $display("Timeout: irWrite did not pulse within 40 cycles");
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Instruction register stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        reset        = 1'b1;
        opcode       = opRType;
        funct        = 6'h00;
        overflowFlag = 1'b0;
        timeoutCount = 0;
        repeat (2) @(posedge clk);
        #5 reset = 1'b0;

        for (int i = 0; i < 16 && timeoutCount == 0; i++)
        begin
            waitForIrWrite();
            if (timeoutCount == 0)
            begin
                @(posedge clk);
                #5;
                {pulseOverflow, opcode, funct} = scriptEntry(i);  // New IR contents
                if (pulseOverflow)
                begin
                    @(posedge clk);
                    #5 overflowFlag = 1'b1;      // During the execute phase
                    @(posedge clk);
                    #5 overflowFlag = 1'b0;
                end
            end
        end
        if (timeoutCount == 0)
        begin
            waitForIrWrite();                    // Last instruction retires
            @(posedge clk);                      // Refetch after the exception is sampled
            #5;
        end

        $display("Summary: %0d check failures, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== controlUnit.f ====
logic/isaPkg.sv
logic/controlPkg.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/controlDecoder.sv
logic/controlUnit.sv
verification/controlChecker.sv
verification/controlUnitTb.sv

// ==== runSim.sh ====
#!/bin/bash
# Builds with Verilator, runs the testbench and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f controlUnit.f --top-module controlUnitTb \
    -o controlUnitSim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/controlUnitSim > sim.log 2>&1
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } || \
    { grep -q "Test completed successfully" sim.log && echo "Simulation passed" || \
    { echo "Simulation did not finish"; exit 1; }; }
